// ==== Bender.yml ====
package:
  name: idu

sources:
  - files:
      - hdl/idu_pkg.sv
      - hdl/op_decoder.sv
      - hdl/imm_gen.sv
      - hdl/operand_forward.sv
      - hdl/decode_reg.sv
      - hdl/idu_top.sv
  - target: test
    files:
      - bench/idu_tb.sv

// ==== bench/idu_tb.sv ====
module idu_tb import idu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic      clk_i, arst_n_i, if_valid_i, if_ready_o, flush_i, ex_ready_i;
    logic      alu_wb_valid_i, alu_wb_load_i, lsu_wb_valid_i, lsu_wb_load_i, rfw_valid_i;
    logic      ex_valid_o, ex_wb_en_o;
    word_t     if_ins_i, if_pc_i, rf_rs1_data_i, rf_rs2_data_i;
    word_t     alu_wb_data_i, lsu_wb_data_i, rfw_data_i;
    word_t     ex_src1_o, ex_src2_o, ex_imm_o, ex_pc_o;
    reg_addr_t rf_rs1_addr_o, rf_rs2_addr_o, alu_wb_addr_i, lsu_wb_addr_i, rfw_addr_i;
    reg_addr_t ex_rd_o;
    alu_op_e   ex_op_o;

    word_t rf [32];
    int    n_err;
    int    n_ok;
    int    n_bad;
    int    seed;

    idu_top idu_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // register file model read in the same cycle
    assign rf_rs1_data_i = rf[rf_rs1_addr_o];
    assign rf_rs2_data_i = rf[rf_rs2_addr_o];

    task automatic cmp_op(input string name, input alu_op_e act, input alu_op_e exp);
        if (act !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, act, exp);
            n_err++;
        end
    endtask

    task automatic cmp_word(input string name, input word_t act, input word_t exp);
        if (act !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, act, exp);
            n_err++;
        end
    endtask

    task automatic cmp_addr(input string name, input reg_addr_t act, input reg_addr_t exp);
        if (act !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, act, exp);
            n_err++;
        end
    endtask

    task automatic cmp_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, act, exp);
            n_err++;
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        if (n_err == err0) begin
            n_ok++;
            $display("%s: ok", name);
        end else begin
            n_bad++;
            $display("%s: %0d errors", name, n_err - err0);
        end
    endtask

    // encoders take the immediate as its plain value
    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input word_t imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input word_t imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(input word_t imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t j_type(input word_t imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // expected operand from the first valid match in execute, memory, write order
    function automatic word_t exp_src(input reg_addr_t a);
        if (a == 0)
            return '0;
        if (alu_wb_valid_i && alu_wb_addr_i == a)
            return alu_wb_data_i;
        if (lsu_wb_valid_i && lsu_wb_addr_i == a)
            return lsu_wb_data_i;
        if (rfw_valid_i && rfw_addr_i == a)
            return rfw_data_i;
        return rf[a];
    endfunction

    task automatic set_fwd(input logic av, input logic al, input reg_addr_t aa,
                           input word_t ad, input logic lv, input logic ll,
                           input reg_addr_t la, input word_t ld, input logic wv,
                           input reg_addr_t wa, input word_t wd);
        alu_wb_valid_i = av;
        alu_wb_load_i  = al;
        alu_wb_addr_i  = aa;
        alu_wb_data_i  = ad;
        lsu_wb_valid_i = lv;
        lsu_wb_load_i  = ll;
        lsu_wb_addr_i  = la;
        lsu_wb_data_i  = ld;
        rfw_valid_i    = wv;
        rfw_addr_i     = wa;
        rfw_data_i     = wd;
    endtask

    // offer one instruction and return just after the accepting edge
    task automatic send(input word_t ins, input word_t pc);
        int n;
        n = 0;
        if_valid_i = 1'b1;
        if_ins_i   = ins;
        if_pc_i    = pc;
        #5;
        cmp_addr("rf_rs1_addr_o", rf_rs1_addr_o, ins[19:15]);
        cmp_addr("rf_rs2_addr_o", rf_rs2_addr_o, ins[24:20]);
        while (!if_ready_o && n < 20) begin
            @(posedge clk_i);
            #15;
            n++;
        end
        if (!if_ready_o) begin
            $display("timeout: decode never accepted the instruction at pc %h", pc);
            n_err++;
        end
        @(posedge clk_i);
        #10;
        if_valid_i = 1'b0;
    endtask

    task automatic issue(input word_t ins, input word_t pc, input alu_op_e op,
                         input word_t s1, input word_t s2, input word_t imm, input logic wb);
        send(ins, pc);
        cmp_bit("ex_valid_o", ex_valid_o, 1'b1);
        cmp_op("ex_op_o", ex_op_o, op);
        cmp_word("ex_src1_o", ex_src1_o, s1);
        cmp_word("ex_src2_o", ex_src2_o, s2);
        cmp_word("ex_imm_o", ex_imm_o, imm);
        cmp_word("ex_pc_o", ex_pc_o, pc);
        cmp_addr("ex_rd_o", ex_rd_o, ins[11:7]);
        cmp_bit("ex_wb_en_o", ex_wb_en_o, wb);
    endtask

    task automatic reset_state();
        int err0;
        err0 = n_err;
        #5;
        cmp_bit("ex_valid_o", ex_valid_o, 1'b0);
        cmp_bit("if_ready_o", if_ready_o, 1'b1);
        finish_test("reset state", err0);
    endtask

    task automatic alu_ops();
        int err0;
        err0 = n_err;
        issue(r_type(FUNCT7_NORM, FUNCT3_ADD, 3, 1, 2), 32'h100, ADD, rf[1], rf[2], '0, 1'b1);
        issue(r_type(FUNCT7_ALT, FUNCT3_ADD, 4, 5, 6), 32'h104, SUB, rf[5], rf[6], '0, 1'b1);
        issue(r_type(FUNCT7_NORM, FUNCT3_SR, 7, 8, 9), 32'h108, SRL, rf[8], rf[9], '0, 1'b1);
        issue(r_type(FUNCT7_ALT, FUNCT3_SR, 10, 11, 12), 32'h10c, SRA, rf[11], rf[12], '0, 1'b1);
        issue(r_type(FUNCT7_NORM, FUNCT3_SLTU, 13, 14, 15), 32'h110, SLTU, rf[14], rf[15],
              '0, 1'b1);
        issue(i_type(-5, 15, FUNCT3_ADD, 14, OPC_OP_IMM), 32'h114, ADD, rf[15], -5, '0, 1'b1);
        issue(i_type(32'h7ff, 17, FUNCT3_XOR, 16, OPC_OP_IMM), 32'h118, XOR, rf[17],
              32'h7ff, '0, 1'b1);
        issue(i_type(32'h403, 19, FUNCT3_SR, 18, OPC_OP_IMM), 32'h11c, SRA, rf[19],
              32'h403, '0, 1'b1);
        issue(i_type(32'h005, 19, FUNCT3_SR, 18, OPC_OP_IMM), 32'h120, SRL, rf[19],
              32'h005, '0, 1'b1);
        // funct7 outside the base set
        send(r_type(7'h01, FUNCT3_ADD, 3, 1, 2), 32'h124);
        cmp_op("ex_op_o", ex_op_o, OP_NONE);
        cmp_bit("ex_wb_en_o", ex_wb_en_o, 1'b0);
        finish_test("r and i types", err0);
    endtask

    task automatic immediates();
        word_t ins;
        int    err0;
        err0 = n_err;
        issue(s_type(-12, 6, 5, FUNCT3_W), 32'h200, SW, rf[5], rf[6], -12, 1'b0);
        issue(s_type(32'h7f, 7, 8, FUNCT3_B), 32'h204, SB, rf[8], rf[7], 32'h7f, 1'b0);
        issue(b_type(-8, 2, 1, FUNCT3_BEQ), 32'h208, BEQ, rf[1], rf[2], -8, 1'b0);
        issue(b_type(4094, 4, 3, FUNCT3_BGEU), 32'h20c, BGEU, rf[3], rf[4], 4094, 1'b0);
        ins = {20'habcde, 5'd5, OPC_LUI};
        issue(ins, 32'h210, LUI, rf[ins[19:15]], 32'habcde000, '0, 1'b1);
        ins = {20'h80001, 5'd6, OPC_AUIPC};
        issue(ins, 32'h214, AUIPC, rf[ins[19:15]], 32'h80001000, '0, 1'b1);
        ins = j_type(-2048, 1);
        issue(ins, 32'h218, JAL, rf[ins[19:15]], -2048, '0, 1'b1);
        ins = j_type(32'h75432, 2);
        issue(ins, 32'h21c, JAL, rf[ins[19:15]], 32'h75432, '0, 1'b1);
        issue(i_type(100, 2, FUNCT3_ADD, 1, OPC_JALR), 32'h220, JALR, rf[2], 100, '0, 1'b1);
        issue(i_type(-4, 3, FUNCT3_W, 8, OPC_LOAD), 32'h224, LW, rf[3], -4, '0, 1'b1);
        issue(i_type(32'h7fc, 9, FUNCT3_BU, 10, OPC_LOAD), 32'h228, LBU, rf[9], 32'h7fc,
              '0, 1'b1);
        finish_test("immediates", err0);
    endtask

    task automatic forwarding();
        int err0;
        err0 = n_err;
        set_fwd(1'b1, 1'b0, 7, 32'haaaa0001, 1'b1, 1'b0, 7, 32'hbbbb0002, 1'b1, 8, 32'hcccc0003);
        issue(r_type(FUNCT7_NORM, FUNCT3_ADD, 9, 7, 8), 32'h300, ADD, exp_src(7), exp_src(8),
              '0, 1'b1);
        set_fwd(1'b0, 1'b0, 7, 32'haaaa0001, 1'b1, 1'b0, 7, 32'hbbbb0002, 1'b1, 7, 32'hcccc0003);
        issue(r_type(FUNCT7_NORM, FUNCT3_XOR, 9, 7, 7), 32'h304, XOR, exp_src(7), exp_src(7),
              '0, 1'b1);
        // x0 never takes forwarded data
        set_fwd(1'b1, 1'b0, 0, 32'haaaa0001, 1'b1, 1'b0, 0, 32'hbbbb0002, 1'b1, 0, 32'hcccc0003);
        issue(r_type(FUNCT7_NORM, FUNCT3_OR, 9, 0, 0), 32'h308, OR, '0, '0, '0, 1'b1);
        // load match on the rs2 field of an I type must not stall
        set_fwd(1'b1, 1'b1, 21, 32'haaaa0001, 1'b0, 1'b0, 0, 32'hbbbb0002, 1'b1, 9, 32'hcccc0003);
        issue(i_type(32'h0b5, 9, FUNCT3_ADD, 10, OPC_OP_IMM), 32'h30c, ADD, exp_src(9),
              32'h0b5, '0, 1'b1);
        set_fwd(1'b0, 1'b0, 0, '0, 1'b0, 1'b0, 0, '0, 1'b1, 12, 32'hcccc0004);
        issue(r_type(FUNCT7_NORM, FUNCT3_AND, 9, 11, 12), 32'h310, AND, rf[11], exp_src(12),
              '0, 1'b1);
        set_fwd(1'b0, 1'b0, 0, '0, 1'b0, 1'b0, 0, '0, 1'b0, 0, '0);
        finish_test("forwarding priority", err0);
    endtask

    task automatic load_use();
        word_t ins;
        int    err0;
        err0 = n_err;
        ins = r_type(FUNCT7_NORM, FUNCT3_ADD, 3, 5, 2);
        set_fwd(1'b1, 1'b1, 5, 32'haaaa0005, 1'b1, 1'b0, 5, 32'hbbbb0005, 1'b0, 0, '0);
        if_valid_i = 1'b1;
        if_ins_i   = ins;
        if_pc_i    = 32'h400;
        repeat (3) begin
            #5;
            cmp_bit("if_ready_o", if_ready_o, 1'b0);
            @(posedge clk_i);
            #10;
            cmp_bit("ex_valid_o", ex_valid_o, 1'b0);
        end
        // load moves on to memory with its data
        set_fwd(1'b0, 1'b0, 0, '0, 1'b1, 1'b0, 5, 32'hbbbb0005, 1'b0, 0, '0);
        issue(ins, 32'h400, ADD, exp_src(5), rf[2], '0, 1'b1);
        ins = s_type(16, 6, 1, FUNCT3_W);
        set_fwd(1'b0, 1'b0, 0, '0, 1'b1, 1'b1, 6, 32'hbbbb0006, 1'b0, 0, '0);
        if_valid_i = 1'b1;
        if_ins_i   = ins;
        if_pc_i    = 32'h404;
        #5;
        cmp_bit("if_ready_o", if_ready_o, 1'b0);
        @(posedge clk_i);
        #10;
        set_fwd(1'b0, 1'b0, 0, '0, 1'b0, 1'b0, 0, '0, 1'b0, 0, '0);
        issue(ins, 32'h404, SW, rf[1], rf[6], 16, 1'b0);
        finish_test("load-use stall", err0);
    endtask

    task automatic flow_control();
        time t0;
        int  err0;
        err0 = n_err;
        issue(i_type(1, 1, FUNCT3_ADD, 2, OPC_OP_IMM), 32'h500, ADD, rf[1], 1, '0, 1'b1);
        ex_ready_i = 1'b0;
        if_valid_i = 1'b1;
        if_ins_i   = i_type(2, 1, FUNCT3_ADD, 3, OPC_OP_IMM);
        if_pc_i    = 32'h504;
        repeat (3) begin
            #5;
            cmp_bit("if_ready_o", if_ready_o, 1'b0);
            @(posedge clk_i);
            #10;
            cmp_bit("ex_valid_o", ex_valid_o, 1'b1);
            cmp_word("ex_pc_o", ex_pc_o, 32'h500);
            cmp_word("ex_src2_o", ex_src2_o, 1);
        end
        ex_ready_i = 1'b1;
        issue(i_type(2, 1, FUNCT3_ADD, 3, OPC_OP_IMM), 32'h504, ADD, rf[1], 2, '0, 1'b1);
        t0 = $time;
        for (int k = 0; k < 4; k++) begin
            issue(i_type(k, 4, FUNCT3_ADD, 5'(k + 1), OPC_OP_IMM), 32'h600 + 4 * k, ADD,
                  rf[4], k, '0, 1'b1);
        end
        if ($time - t0 != 400) begin
            $display("stream of four took %0d ns instead of four cycles", $time - t0);
            n_err++;
        end
        issue(i_type(7, 1, FUNCT3_ADD, 5, OPC_OP_IMM), 32'h700, ADD, rf[1], 7, '0, 1'b1);
        ex_ready_i = 1'b0;
        // flush drops the held item while execute stalls
        flush_i    = 1'b1;
        if_valid_i = 1'b1;
        if_ins_i   = i_type(8, 1, FUNCT3_ADD, 6, OPC_OP_IMM);
        if_pc_i    = 32'h704;
        @(posedge clk_i);
        #10;
        cmp_bit("ex_valid_o", ex_valid_o, 1'b0);
        // the offer would load here without the flush
        ex_ready_i = 1'b1;
        #5;
        cmp_bit("if_ready_o", if_ready_o, 1'b1);
        @(posedge clk_i);
        #10;
        flush_i    = 1'b0;
        if_valid_i = 1'b0;
        cmp_bit("ex_valid_o", ex_valid_o, 1'b0);
        cmp_word("ex_pc_o", ex_pc_o, 32'h700);
        finish_test("back-pressure and flush", err0);
    endtask

    initial begin
        seed       = $urandom(68857);
        n_err      = 0;
        n_ok       = 0;
        n_bad      = 0;
        arst_n_i   = 1'b0;
        if_valid_i = 1'b0;
        if_ins_i   = '0;
        if_pc_i    = '0;
        flush_i    = 1'b0;
        ex_ready_i = 1'b1;
        set_fwd(1'b0, 1'b0, 0, '0, 1'b0, 1'b0, 0, '0, 1'b0, 0, '0);
        for (int r = 0; r < 32; r++)
            rf[r] = (r == 0) ? '0 : $urandom;
        repeat (5) @(posedge clk_i);
        #10;
        arst_n_i = 1'b1;
        reset_state();
        alu_ops();
        immediates();
        forwarding();
        load_use();
        flow_control();
        $display("tests passed: %0d, tests failed: %0d", n_ok, n_bad);
        if (n_bad == 0 && n_err == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hdl/idu_pkg.sv
hdl/op_decoder.sv
hdl/imm_gen.sv
hdl/operand_forward.sv
hdl/decode_reg.sv
hdl/idu_top.sv
bench/idu_tb.sv

// ==== hdl/decode_reg.sv ====
module decode_reg import idu_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      if_valid_i,
    input  logic      flush_i,
    input  logic      stall_i,
    input  logic      ex_ready_i,
    input  alu_op_e   op_i,
    input  word_t     src1_i,
    input  word_t     src2_i,
    input  word_t     imm_i,
    input  word_t     pc_i,
    input  reg_addr_t rd_i,
    input  logic      wb_en_i,
    output logic      if_ready_o,
    output logic      ex_valid_o,
    output alu_op_e   ex_op_o,
    output word_t     ex_src1_o,
    output word_t     ex_src2_o,
    output word_t     ex_imm_o,
    output word_t     ex_pc_o,
    output reg_addr_t ex_rd_o,
    output logic      ex_wb_en_o
);

    logic accept;

    // slot frees up on the same edge execute takes it
    assign if_ready_o = (~ex_valid_o | ex_ready_i) & ~stall_i;
    assign accept     = if_valid_i & if_ready_o & ~flush_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o <= 1'b0;
        end else if (flush_i) begin
            ex_valid_o <= 1'b0;
        end else if (accept) begin
            ex_valid_o <= 1'b1;
        end else if (ex_ready_i) begin
            ex_valid_o <= 1'b0;
        end
    end

    // payload only moves on acceptance, so it holds under back-pressure
    always_ff @(posedge clk_i) begin
        if (accept) begin
            ex_op_o    <= op_i;
            ex_src1_o  <= src1_i;
            ex_src2_o  <= src2_i;
            ex_imm_o   <= imm_i;
            ex_pc_o    <= pc_i;
            ex_rd_o    <= rd_i;
            ex_wb_en_o <= wb_en_i;
        end
    end

endmodule

// ==== hdl/idu_pkg.sv ====
package idu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // alu funct3
    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SR   = 3'b101;
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    // branch, load and store funct3
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;
    localparam logic [2:0] FUNCT3_B    = 3'b000;
    localparam logic [2:0] FUNCT3_H    = 3'b001;
    localparam logic [2:0] FUNCT3_W    = 3'b010;
    localparam logic [2:0] FUNCT3_BU   = 3'b100;
    localparam logic [2:0] FUNCT3_HU   = 3'b101;

    localparam logic [6:0] FUNCT7_NORM = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    typedef enum logic [4:0] {
        OP_NONE,
        ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        LUI, AUIPC, JAL, JALR
    } alu_op_e;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE
    } ins_fmt_e;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

// ==== hdl/idu_top.sv ====
module idu_top import idu_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    // fetch
    input  logic      if_valid_i,
    input  word_t     if_ins_i,
    input  word_t     if_pc_i,
    output logic      if_ready_o,
    // register file read
    output reg_addr_t rf_rs1_addr_o,
    output reg_addr_t rf_rs2_addr_o,
    input  word_t     rf_rs1_data_i,
    input  word_t     rf_rs2_data_i,
    // forwarding sources
    input  logic      alu_wb_valid_i,
    input  logic      alu_wb_load_i,
    input  reg_addr_t alu_wb_addr_i,
    input  word_t     alu_wb_data_i,
    input  logic      lsu_wb_valid_i,
    input  logic      lsu_wb_load_i,
    input  reg_addr_t lsu_wb_addr_i,
    input  word_t     lsu_wb_data_i,
    input  logic      rfw_valid_i,
    input  reg_addr_t rfw_addr_i,
    input  word_t     rfw_data_i,
    // execute
    input  logic      flush_i,
    input  logic      ex_ready_i,
    output logic      ex_valid_o,
    output alu_op_e   ex_op_o,
    output word_t     ex_src1_o,
    output word_t     ex_src2_o,
    output word_t     ex_imm_o,
    output word_t     ex_pc_o,
    output reg_addr_t ex_rd_o,
    output logic      ex_wb_en_o
);

    alu_op_e   dec_op;
    ins_fmt_e  dec_fmt;
    logic      dec_wb_en;
    logic      use_rs1;
    logic      use_rs2;
    word_t     opnd_imm;
    word_t     br_st_imm;
    word_t     fwd_src1;
    word_t     fwd_src2;
    word_t     src2_nxt;
    logic      stall;
    reg_addr_t rd;

    assign rf_rs1_addr_o = if_ins_i[19:15];
    assign rf_rs2_addr_o = if_ins_i[24:20];
    assign rd            = if_ins_i[11:7];

    op_decoder op_decoder_inst (
        .ins_i     (if_ins_i),
        .op_o      (dec_op),
        .fmt_o     (dec_fmt),
        .wb_en_o   (dec_wb_en),
        .use_rs1_o (use_rs1),
        .use_rs2_o (use_rs2)
    );

    imm_gen imm_gen_inst (
        .ins_i       (if_ins_i),
        .fmt_i       (dec_fmt),
        .opnd_imm_o  (opnd_imm),
        .br_st_imm_o (br_st_imm)
    );

    operand_forward operand_forward_inst (
        .rs1_addr_i     (rf_rs1_addr_o),
        .rs2_addr_i     (rf_rs2_addr_o),
        .use_rs1_i      (use_rs1),
        .use_rs2_i      (use_rs2),
        .rf_rs1_data_i  (rf_rs1_data_i),
        .rf_rs2_data_i  (rf_rs2_data_i),
        .alu_wb_valid_i (alu_wb_valid_i),
        .alu_wb_load_i  (alu_wb_load_i),
        .alu_wb_addr_i  (alu_wb_addr_i),
        .alu_wb_data_i  (alu_wb_data_i),
        .lsu_wb_valid_i (lsu_wb_valid_i),
        .lsu_wb_load_i  (lsu_wb_load_i),
        .lsu_wb_addr_i  (lsu_wb_addr_i),
        .lsu_wb_data_i  (lsu_wb_data_i),
        .rfw_valid_i    (rfw_valid_i),
        .rfw_addr_i     (rfw_addr_i),
        .rfw_data_i     (rfw_data_i),
        .src1_o         (fwd_src1),
        .src2_o         (fwd_src2),
        .stall_o        (stall)
    );

    // I, U and J formats take the immediate as second operand
    assign src2_nxt = (dec_fmt == FMT_I || dec_fmt == FMT_U || dec_fmt == FMT_J) ?
                      opnd_imm : fwd_src2;

    decode_reg decode_reg_inst (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .if_valid_i (if_valid_i),
        .flush_i    (flush_i),
        .stall_i    (stall),
        .ex_ready_i (ex_ready_i),
        .op_i       (dec_op),
        .src1_i     (fwd_src1),
        .src2_i     (src2_nxt),
        .imm_i      (br_st_imm),
        .pc_i       (if_pc_i),
        .rd_i       (rd),
        .wb_en_i    (dec_wb_en),
        .if_ready_o (if_ready_o),
        .ex_valid_o (ex_valid_o),
        .ex_op_o    (ex_op_o),
        .ex_src1_o  (ex_src1_o),
        .ex_src2_o  (ex_src2_o),
        .ex_imm_o   (ex_imm_o),
        .ex_pc_o    (ex_pc_o),
        .ex_rd_o    (ex_rd_o),
        .ex_wb_en_o (ex_wb_en_o)
    );

endmodule

// ==== hdl/imm_gen.sv ====
module imm_gen import idu_pkg::*; (
    input  word_t    ins_i,
    input  ins_fmt_e fmt_i,
    output word_t    opnd_imm_o,
    output word_t    br_st_imm_o
);

    word_t i_imm;
    word_t s_imm;
    word_t b_imm;
    word_t u_imm;
    word_t j_imm;

    assign i_imm = {{(XLEN-12){ins_i[31]}}, ins_i[31:20]};
    assign s_imm = {{(XLEN-12){ins_i[31]}}, ins_i[31:25], ins_i[11:7]};

    // b and j offsets are halfword aligned
    assign b_imm = {{(XLEN-13){ins_i[31]}}, ins_i[31], ins_i[7], ins_i[30:25],
                    ins_i[11:8], 1'b0};
    assign j_imm = {{(XLEN-21){ins_i[31]}}, ins_i[31], ins_i[19:12], ins_i[20],
                    ins_i[30:21], 1'b0};

    assign u_imm = {ins_i[31:12], 12'b0};

    // immediate used as the second operand
    always_comb begin
        case (fmt_i)
            FMT_I:   opnd_imm_o = i_imm;
            FMT_U:   opnd_imm_o = u_imm;
            FMT_J:   opnd_imm_o = j_imm;
            default: opnd_imm_o = '0;
        endcase
    end

    // target or address offset for branches and stores
    always_comb begin
        case (fmt_i)
            FMT_B:   br_st_imm_o = b_imm;
            FMT_S:   br_st_imm_o = s_imm;
            default: br_st_imm_o = '0;
        endcase
    end

endmodule

// ==== hdl/op_decoder.sv ====
module op_decoder import idu_pkg::*; (
    input  word_t    ins_i,
    output alu_op_e  op_o,
    output ins_fmt_e fmt_o,
    output logic     wb_en_o,
    output logic     use_rs1_o,
    output logic     use_rs2_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_norm;
    logic       f7_alt;
    alu_op_e    op;
    ins_fmt_e   fmt_raw;

    // shared by OP and OP_IMM, funct7 checked by the caller
    function automatic alu_op_e alu_base(input logic [2:0] f3);
        case (f3)
            FUNCT3_ADD:  return ADD;
            FUNCT3_SLL:  return SLL;
            FUNCT3_SLT:  return SLT;
            FUNCT3_SLTU: return SLTU;
            FUNCT3_XOR:  return XOR;
            FUNCT3_SR:   return SRL;
            FUNCT3_OR:   return OR;
            default:     return AND;
        endcase
    endfunction

    assign opcode  = ins_i[6:0];
    assign funct3  = ins_i[14:12];
    assign funct7  = ins_i[31:25];
    assign f7_norm = (funct7 == FUNCT7_NORM);
    assign f7_alt  = (funct7 == FUNCT7_ALT);

    always_comb begin
        case (opcode)
            OPC_OP:                         fmt_raw = FMT_R;
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: fmt_raw = FMT_I;
            OPC_STORE:                      fmt_raw = FMT_S;
            OPC_BRANCH:                     fmt_raw = FMT_B;
            OPC_LUI, OPC_AUIPC:             fmt_raw = FMT_U;
            OPC_JAL:                        fmt_raw = FMT_J;
            default:                        fmt_raw = FMT_NONE;
        endcase
    end

    always_comb begin
        op = OP_NONE;
        case (opcode)
            OPC_OP: begin
                if (f7_norm) begin
                    op = alu_base(funct3);
                end else if (f7_alt && funct3 == FUNCT3_ADD) begin
                    op = SUB;
                end else if (f7_alt && funct3 == FUNCT3_SR) begin
                    op = SRA;
                end
            end
            OPC_OP_IMM: begin
                // only shifts carry funct7, the rest is immediate
                if (funct3 == FUNCT3_SLL) begin
                    op = f7_norm ? SLL : OP_NONE;
                end else if (funct3 == FUNCT3_SR) begin
                    op = f7_norm ? SRL : (f7_alt ? SRA : OP_NONE);
                end else begin
                    op = alu_base(funct3);
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    FUNCT3_BEQ:  op = BEQ;
                    FUNCT3_BNE:  op = BNE;
                    FUNCT3_BLT:  op = BLT;
                    FUNCT3_BGE:  op = BGE;
                    FUNCT3_BLTU: op = BLTU;
                    FUNCT3_BGEU: op = BGEU;
                    default:     op = OP_NONE;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    FUNCT3_B:  op = LB;
                    FUNCT3_H:  op = LH;
                    FUNCT3_W:  op = LW;
                    FUNCT3_BU: op = LBU;
                    FUNCT3_HU: op = LHU;
                    default:   op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    FUNCT3_B: op = SB;
                    FUNCT3_H: op = SH;
                    FUNCT3_W: op = SW;
                    default:  op = OP_NONE;
                endcase
            end
            OPC_LUI:   op = LUI;
            OPC_AUIPC: op = AUIPC;
            OPC_JAL:   op = JAL;
            OPC_JALR:  op = (funct3 == FUNCT3_ADD) ? JALR : OP_NONE;
            default:   op = OP_NONE;
        endcase
    end

    assign op_o  = op;
    assign fmt_o = (op == OP_NONE) ? FMT_NONE : fmt_raw;

    assign wb_en_o   = (fmt_o == FMT_R) | (fmt_o == FMT_I) | (fmt_o == FMT_U) | (fmt_o == FMT_J);
    assign use_rs1_o = ~((fmt_o == FMT_U) | (fmt_o == FMT_J));
    assign use_rs2_o = (fmt_o == FMT_R) | (fmt_o == FMT_S) | (fmt_o == FMT_B);

endmodule

// ==== hdl/operand_forward.sv ====
module operand_forward import idu_pkg::*; (
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  logic      use_rs1_i,
    input  logic      use_rs2_i,
    input  word_t     rf_rs1_data_i,
    input  word_t     rf_rs2_data_i,
    input  logic      alu_wb_valid_i,
    input  logic      alu_wb_load_i,
    input  reg_addr_t alu_wb_addr_i,
    input  word_t     alu_wb_data_i,
    input  logic      lsu_wb_valid_i,
    input  logic      lsu_wb_load_i,
    input  reg_addr_t lsu_wb_addr_i,
    input  word_t     lsu_wb_data_i,
    input  logic      rfw_valid_i,
    input  reg_addr_t rfw_addr_i,
    input  word_t     rfw_data_i,
    output word_t     src1_o,
    output word_t     src2_o,
    output logic      stall_o
);

    // index 0 is rs1, index 1 is rs2
    reg_addr_t  rs_addr [2];
    logic [1:0] rs_used;
    word_t      rf_data [2];
    logic [1:0] hit_alu;
    logic [1:0] hit_lsu;
    logic [1:0] hit_rfw;
    logic [1:0] ld_pend;
    word_t      fwd_data [2];

    assign rs_addr[0] = rs1_addr_i;
    assign rs_addr[1] = rs2_addr_i;
    assign rs_used    = {use_rs2_i, use_rs1_i};
    assign rf_data[0] = rf_rs1_data_i;
    assign rf_data[1] = rf_rs2_data_i;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // x0 never forwards
            hit_alu[i] = alu_wb_valid_i & (alu_wb_addr_i == rs_addr[i]) &
                         (|rs_addr[i]) & rs_used[i];
            hit_lsu[i] = lsu_wb_valid_i & (lsu_wb_addr_i == rs_addr[i]) &
                         (|rs_addr[i]) & rs_used[i];
            hit_rfw[i] = rfw_valid_i & (rfw_addr_i == rs_addr[i]) &
                         (|rs_addr[i]) & rs_used[i];

            // youngest writer wins
            if (hit_alu[i]) begin
                fwd_data[i] = alu_wb_data_i;
                ld_pend[i]  = alu_wb_load_i;
            end else if (hit_lsu[i]) begin
                fwd_data[i] = lsu_wb_data_i;
                ld_pend[i]  = lsu_wb_load_i;
            end else if (hit_rfw[i]) begin
                fwd_data[i] = rfw_data_i;
                ld_pend[i]  = 1'b0;
            end else begin
                fwd_data[i] = rf_data[i];
                ld_pend[i]  = 1'b0;
            end
        end
    end

    assign src1_o  = fwd_data[0];
    assign src2_o  = fwd_data[1];

    // load data not back yet
    assign stall_o = |ld_pend;

endmodule
